// File: flist.f
source/game_pkg.sv
source/vga_timing.sv
source/draw_background.sv
source/draw_rect.sv
source/hero_motion.sv
source/game_ctl.sv
source/game_top.sv
verification/game_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := game_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/game_tb.sv
`timescale 1ns/10ps
`default_nettype none

module game_tb;
    import game_pkg::*;

    // small 64x48 picture, 80 x 54 cycles per frame
    localparam int H_ACT = 64;
    localparam int H_FP  = 4;
    localparam int H_SW  = 8;
    localparam int H_BP  = 4;
    localparam int V_ACT = 48;
    localparam int V_FP  = 2;
    localparam int V_SW  = 2;
    localparam int V_BP  = 2;
    localparam int H_TOT = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOT = V_ACT + V_FP + V_SW + V_BP;
    localparam int FRAME = H_TOT * V_TOT;

    // the whole run needs about 60 frames
    localparam int CYCLE_LIMIT = 80 * FRAME;
    localparam int CLK_HALF    = 20;

    localparam time_t START_TIME = 8'd12;

    logic   clk;
    logic   rst_n;
    btn_t   btn;
    logic   hs;
    logic   vs;
    rgb_t   rgb;
    level_t level;
    time_t  time_left;

    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     cycles = 0;
    integer seed = 32'h650b9bd0;

    // pixel tracker state
    event   pix_ev;
    int     px = 0;
    int     py = 0;
    logic   pos_ok = 1'b0;
    logic   hs_prev = 1'b1;
    logic   vs_prev = 1'b1;
    logic   vs_fell = 1'b0;
    logic   hs_s;
    logic   vs_s;
    rgb_t   rgb_s;

    game_top #(
        .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP),
        .FRAMES_PER_TICK(2), .LEVEL_TIME(12)
    ) game_top_i (
        .clk(clk), .rst_n(rst_n), .btn(btn), .hs(hs), .vs(vs), .rgb(rgb),
        .level(level), .time_left(time_left)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // position of the output pixel, rebuilt from the sync edges
    initial begin
        forever begin
            @(negedge clk);
            hs_s  = hs;
            vs_s  = vs;
            rgb_s = rgb;
            if (!rst_n) begin
                pos_ok = 1'b0;
            end
            if (px == H_TOT - 1) begin
                px = 0;
                py = (py == V_TOT - 1) ? 0 : py + 1;
            end else begin
                px++;
            end
            if (hs_prev && !hs_s) begin
                px = H_ACT + H_FP;
            end
            vs_fell = vs_prev && !vs_s;
            if (vs_fell) begin
                px     = 0;
                py     = V_ACT + V_FP;
                pos_ok = 1'b1;
            end
            hs_prev = hs_s;
            vs_prev = vs_s;
            -> pix_ev;
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("FAILURE: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at time %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input level_t got, input level_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_time(input string name, input time_t got, input time_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("FAILURE at time %0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // returns on the output pixel where vs falls, line V_ACT+V_FP
    task automatic wait_vsync();
        do begin
            @(pix_ev);
        end while (!vs_fell);
    endtask

    task automatic probe_pixel(input int x, input int y, input rgb_t exp);
        do begin
            @(pix_ev);
        end while (!(pos_ok && px == x && py == y));
        check_rgb($sformatf("rgb at (%0d,%0d)", x, y), rgb_s, exp);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_sync();
        int e0;
        int n;
        int hs_low;
        int vs_lines;
        e0       = errors;
        n        = 0;
        hs_low   = 0;
        vs_lines = 0;
        wait_vsync();
        do begin
            @(pix_ev);
            n++;
            if (!hs_s) begin
                hs_low++;
            end
            if (px == H_TOT - 1) begin
                check_count("hs low cycles in a line", hs_low, H_SW);
                hs_low = 0;
            end
            if (px == 0 && !vs_s) begin
                vs_lines++;
            end
            if (px >= H_ACT || py >= V_ACT) begin
                check_rgb("rgb in blanking", rgb_s, '0);
            end
        end while (!vs_fell);
        check_count("vs low lines", vs_lines, V_SW);
        check_count("cycles per frame", n, FRAME);
        report_test("test_sync", e0);
    endtask

    task automatic test_reset_picture();
        int e0;
        e0 = errors;
        apply_reset();
        check_bit("hs", hs, 1'b1);
        check_bit("vs", vs, 1'b1);
        check_rgb("rgb", rgb, '0);
        check_level("level", level, '0);
        check_time("time_left", time_left, START_TIME);
        // hero starts at (0,20), goal at (56,0)
        probe_pixel(0, 0, BORDER_COLOR);
        probe_pixel(58, 2, GOAL_COLOR);
        probe_pixel(32, 10, BG_COLOR);
        probe_pixel(2, 22, HERO_COLOR);
        wait_vsync();
        report_test("test_reset_picture", e0);
    endtask

    task automatic test_move();
        int e0;
        e0 = errors;
        btn.right = 1'b1;
        btn.down  = 1'b1;
        // three steps, the picture of the last one is probed
        repeat (2) wait_vsync();
        probe_pixel(2, 22, BG_COLOR);
        probe_pixel(14, 34, HERO_COLOR);
        wait_vsync();
        btn = '0;
        report_test("test_move", e0);
    endtask

    task automatic test_clamp();
        int e0;
        e0 = errors;
        btn.up = 1'b1;
        // y 32 needs 8 steps, the ninth one hits the clamp
        repeat (8) wait_vsync();
        probe_pixel(14, 0, HERO_COLOR);
        probe_pixel(14, 8, BG_COLOR);
        wait_vsync();
        btn = '0;
        report_test("test_clamp", e0);
    endtask

    task automatic test_goal();
        int e0;
        int n;
        e0 = errors;
        n  = 0;
        btn.right = 1'b1;
        while (level != level_t'(1) && n < 16 * FRAME) begin
            @(pix_ev);
            n++;
        end
        btn = '0;
        if (level != level_t'(1)) begin
            report_failure("level did not advance while the hero walked into the goal");
        end
        check_time("time_left", time_left, START_TIME);
        // odd level puts the goal bottom right
        probe_pixel(58, 2, BG_COLOR);
        probe_pixel(2, 22, HERO_COLOR);
        probe_pixel(58, 42, GOAL_COLOR);
        wait_vsync();
        report_test("test_goal", e0);
    endtask

    task automatic test_timeout();
        int    e0;
        int    idle;
        int    frames;
        int    gap;
        int    steps;
        logic  reloaded;
        time_t prev;
        e0       = errors;
        idle     = $random(seed) & 3;
        frames   = 0;
        gap      = 0;
        steps    = 0;
        reloaded = 1'b0;
        repeat (idle) wait_vsync();
        prev = time_left;
        while (!reloaded && frames < 40) begin
            wait_vsync();
            frames++;
            gap++;
            if (time_left != prev) begin
                if (steps > 0) begin
                    check_count("frames between timer ticks", gap, 2);
                end
                if (prev == '0) begin
                    check_time("time_left after timeout", time_left, START_TIME);
                    reloaded = 1'b1;
                end else begin
                    check_time("time_left", time_left, time_t'(prev - 8'd1));
                end
                steps++;
                gap  = 0;
                prev = time_left;
            end
        end
        if (!reloaded) begin
            report_failure("timer did not run out and reload within 40 frames");
        end
        check_level("level", level, level_t'(1));
        probe_pixel(2, 22, HERO_COLOR);
        report_test("test_timeout", e0);
    endtask

    initial begin
        rst_n = 1'b0;
        btn   = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        test_sync();
        test_reset_picture();
        test_move();
        test_clamp();
        test_goal();
        test_timeout();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/game_top.sv
`timescale 1ns/10ps
`default_nettype none

module game_top #(
    parameter int H_ACTIVE        = 1024,
    parameter int H_FRONT         = 24,
    parameter int H_SYNC          = 136,
    parameter int H_BACK          = 160,
    parameter int V_ACTIVE        = 768,
    parameter int V_FRONT         = 3,
    parameter int V_SYNC          = 6,
    parameter int V_BACK          = 29,
    parameter int FRAMES_PER_TICK = 60,
    parameter int LEVEL_TIME      = 60
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::btn_t   btn,
    output logic             hs,
    output logic             vs,
    output game_pkg::rgb_t   rgb,
    output game_pkg::level_t level,
    output game_pkg::time_t  time_left
);
    import game_pkg::*;

    vga_sig_t timing_sig;
    pix_t     bg_pix;
    pix_t     goal_pix;
    pix_t     hero_pix;
    coord_t   hero_x;
    coord_t   hero_y;
    coord_t   goal_x;
    coord_t   goal_y;
    logic     frame_start;
    logic     restart;

    ////////////////////////////////////////
    // pixel pipeline, three stages
    ////////////////////////////////////////

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_i (
        .clk(clk), .rst_n(rst_n), .vga(timing_sig), .frame_start(frame_start)
    );

    draw_background #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) draw_background_i (
        .clk(clk), .rst_n(rst_n), .vga_in(timing_sig), .pix_out(bg_pix)
    );

    draw_rect #(.COLOR(GOAL_COLOR)) goal_rect (
        .clk(clk), .rst_n(rst_n), .pix_in(bg_pix), .x(goal_x), .y(goal_y), .pix_out(goal_pix)
    );

    draw_rect #(.COLOR(HERO_COLOR)) hero_rect (
        .clk(clk), .rst_n(rst_n), .pix_in(goal_pix), .x(hero_x), .y(hero_y), .pix_out(hero_pix)
    );

    // control side
    hero_motion #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) hero_motion_i (
        .clk(clk), .rst_n(rst_n), .frame_start(frame_start), .restart(restart),
        .btn(btn), .hero_x(hero_x), .hero_y(hero_y)
    );

    game_ctl #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
        .FRAMES_PER_TICK(FRAMES_PER_TICK), .LEVEL_TIME(LEVEL_TIME)
    ) game_ctl_i (
        .clk(clk), .rst_n(rst_n), .frame_start(frame_start),
        .hero_x(hero_x), .hero_y(hero_y), .goal_x(goal_x), .goal_y(goal_y),
        .restart(restart), .level(level), .time_left(time_left)
    );

    assign hs  = hero_pix.vga.hsync;
    assign vs  = hero_pix.vga.vsync;
    assign rgb = hero_pix.rgb;

endmodule

`default_nettype wire

// File: source/game_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module game_ctl #(
    parameter int H_ACTIVE        = 1024,
    parameter int V_ACTIVE        = 768,
    parameter int FRAMES_PER_TICK = 60,
    parameter int LEVEL_TIME      = 60
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_start,
    input  game_pkg::coord_t hero_x,
    input  game_pkg::coord_t hero_y,
    output game_pkg::coord_t goal_x,
    output game_pkg::coord_t goal_y,
    output logic             restart,
    output game_pkg::level_t level,
    output game_pkg::time_t  time_left
);
    import game_pkg::*;

    localparam int     FCNT_W     = (FRAMES_PER_TICK > 1) ? $clog2(FRAMES_PER_TICK) : 1;
    localparam coord_t GOAL_X     = coord_t'(H_ACTIVE - GOAL_SIZE);
    localparam coord_t GOAL_Y_LOW = coord_t'(V_ACTIVE - GOAL_SIZE);
    localparam time_t  TIME_INIT  = time_t'(LEVEL_TIME);

    game_state_t       state;
    logic [FCNT_W-1:0] frame_cnt;
    logic              tick;
    logic              overlap;

    // goal sits top right on even levels and bottom right on odd ones
    assign goal_x = GOAL_X;
    assign goal_y = level[0] ? GOAL_Y_LOW : '0;

    assign tick = frame_start && (frame_cnt == FCNT_W'(FRAMES_PER_TICK - 1));

    assign overlap = (hero_x < goal_x + GOAL_SIZE) && (goal_x < hero_x + HERO_SIZE) &&
                     (hero_y < goal_y + GOAL_SIZE) && (goal_y < hero_y + HERO_SIZE);

    // hero goes back to start while not playing
    assign restart = (state != PLAY);

    ////////////////////////////////////////
    // game FSM with level and countdown
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= PLAY;
            level     <= '0;
            time_left <= TIME_INIT;
            frame_cnt <= '0;
        end else begin
            case (state)
                PLAY: begin
                    if (overlap) begin
                        state <= GOAL;
                    end else if (tick) begin
                        if (time_left == '0) begin
                            state <= TIMEOUT;
                        end else begin
                            time_left <= time_left - time_t'(1);
                        end
                    end
                    if (frame_start) begin
                        frame_cnt <= tick ? '0 : frame_cnt + FCNT_W'(1);
                    end
                end
                GOAL: begin
                    state     <= PLAY;
                    level     <= level + level_t'(1);
                    time_left <= TIME_INIT;
                    frame_cnt <= '0;
                end
                TIMEOUT: begin
                    // same level again with a fresh timer
                    state     <= PLAY;
                    time_left <= TIME_INIT;
                    frame_cnt <= '0;
                end
                default: state <= PLAY;
            endcase
        end
    end

    time_left_max: assert property (@(posedge clk) disable iff (!rst_n)
        time_left <= TIME_INIT);

endmodule

`default_nettype wire

// File: source/hero_motion.sv
`timescale 1ns/10ps
`default_nettype none

module hero_motion #(
    parameter int H_ACTIVE = 1024,
    parameter int V_ACTIVE = 768
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_start,
    input  logic             restart,
    input  game_pkg::btn_t   btn,
    output game_pkg::coord_t hero_x,
    output game_pkg::coord_t hero_y
);
    import game_pkg::*;

    localparam coord_t X_MAX   = coord_t'(H_ACTIVE - HERO_SIZE);
    localparam coord_t Y_MAX   = coord_t'(V_ACTIVE - HERO_SIZE);
    localparam coord_t Y_START = coord_t'((V_ACTIVE - HERO_SIZE) / 2);

    ////////////////////////////////////////
    // one step along one axis, clamped
    ////////////////////////////////////////

    function automatic coord_t step_axis(input coord_t pos, input logic inc,
                                         input logic dec, input coord_t lim);
        coord_t res;
        res = pos;
        // both directions together cancel out
        if (inc && !dec) begin
            if (pos + HERO_STEP > lim) begin
                res = lim;
            end else begin
                res = pos + HERO_STEP;
            end
        end else if (dec && !inc) begin
            if (pos < HERO_STEP) begin
                res = '0;
            end else begin
                res = pos - HERO_STEP;
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            hero_x <= '0;
            hero_y <= Y_START;
        end else if (frame_start) begin
            hero_x <= step_axis(hero_x, btn.right, btn.left, X_MAX);
            hero_y <= step_axis(hero_y, btn.down, btn.up, Y_MAX);
        end
    end

    hero_in_bounds: assert property (@(posedge clk) disable iff (!rst_n)
        (hero_x <= X_MAX) && (hero_y <= Y_MAX));

endmodule

`default_nettype wire

// File: source/draw_rect.sv
`timescale 1ns/10ps
`default_nettype none

module draw_rect #(
    parameter game_pkg::rgb_t COLOR = 12'hf_f_f
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::pix_t   pix_in,
    input  game_pkg::coord_t x,
    input  game_pkg::coord_t y,
    output game_pkg::pix_t   pix_out
);
    import game_pkg::*;

    logic in_x;
    logic in_y;
    logic blank;
    rgb_t rgb_nxt;

    // square with top left corner at x,y
    assign in_x  = (pix_in.vga.hcount >= x) && (pix_in.vga.hcount < x + HERO_SIZE);
    assign in_y  = (pix_in.vga.vcount >= y) && (pix_in.vga.vcount < y + HERO_SIZE);
    assign blank = pix_in.vga.hblnk || pix_in.vga.vblnk;

    always_comb begin
        if (in_x && in_y && !blank) begin
            rgb_nxt = COLOR;
        end else begin
            rgb_nxt = pix_in.rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_out <= PIX_IDLE;
        end else begin
            pix_out.vga <= pix_in.vga;
            pix_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/draw_background.sv
`timescale 1ns/10ps
`default_nettype none

module draw_background #(
    parameter int H_ACTIVE = 1024,
    parameter int V_ACTIVE = 768
) (
    input  logic               clk,
    input  logic               rst_n,
    input  game_pkg::vga_sig_t vga_in,
    output game_pkg::pix_t     pix_out
);
    import game_pkg::*;

    logic border;
    rgb_t rgb_nxt;

    // outermost row and column of the active area
    assign border = (vga_in.hcount == '0) || (vga_in.hcount == coord_t'(H_ACTIVE - 1)) ||
                    (vga_in.vcount == '0) || (vga_in.vcount == coord_t'(V_ACTIVE - 1));

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = '0;
        end else if (border) begin
            rgb_nxt = BORDER_COLOR;
        end else begin
            rgb_nxt = BG_COLOR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_out <= PIX_IDLE;
        end else begin
            pix_out.vga <= vga_in;
            pix_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FRONT  = 24,
    parameter int H_SYNC   = 136,
    parameter int H_BACK   = 160,
    parameter int V_ACTIVE = 768,
    parameter int V_FRONT  = 3,
    parameter int V_SYNC   = 6,
    parameter int V_BACK   = 29
) (
    input  logic               clk,
    input  logic               rst_n,
    output game_pkg::vga_sig_t vga,
    output logic               frame_start
);
    import game_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam coord_t H_SYNC_START = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t H_SYNC_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t V_SYNC_START = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t V_SYNC_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t h_next;
    coord_t v_next;

    // next counter values, the decode below works on these so that
    // syncs and blanking stay aligned with the counters
    always_comb begin
        h_next = vga.hcount + coord_t'(1);
        v_next = vga.vcount;
        if (vga.hcount == coord_t'(H_TOTAL - 1)) begin
            h_next = '0;
            if (vga.vcount == coord_t'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = vga.vcount + coord_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga <= VGA_IDLE;
        end else begin
            vga.hcount <= h_next;
            vga.vcount <= v_next;
            vga.hsync  <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
            vga.vsync  <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
            vga.hblnk  <= (h_next >= coord_t'(H_ACTIVE));
            vga.vblnk  <= (v_next >= coord_t'(V_ACTIVE));
        end
    end

    // top left pixel of the frame
    assign frame_start = (vga.hcount == '0) && (vga.vcount == '0);

    hcount_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        vga.hcount < coord_t'(H_TOTAL));

endmodule

`default_nettype wire

// File: source/game_pkg.sv
`default_nettype none

package game_pkg;

    ////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////

    typedef logic [10:0] coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [3:0]  level_t;
    typedef logic [7:0]  time_t;

    // timing bundle, syncs are active low
    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
    } vga_sig_t;

    // what one pipeline stage hands to the next
    typedef struct packed {
        vga_sig_t vga;
        rgb_t     rgb;
    } pix_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } btn_t;

    typedef enum logic [1:0] {
        PLAY,
        GOAL,
        TIMEOUT
    } game_state_t;

    ////////////////////////////////////////
    // colors and sizes
    ////////////////////////////////////////

    localparam rgb_t BG_COLOR     = 12'h3_3_3;
    localparam rgb_t BORDER_COLOR = 12'hf_f_f;
    localparam rgb_t GOAL_COLOR   = 12'hf_0_0;
    localparam rgb_t HERO_COLOR   = 12'h0_1_c;

    localparam coord_t HERO_SIZE = 11'd8;
    localparam coord_t GOAL_SIZE = 11'd8;
    localparam coord_t HERO_STEP = 11'd4;

    // idle values, syncs inactive and picture black
    localparam vga_sig_t VGA_IDLE = '{hcount: '0, vcount: '0, hsync: 1'b1,
                                      vsync: 1'b1, hblnk: 1'b0, vblnk: 1'b0};
    localparam pix_t PIX_IDLE = '{vga: VGA_IDLE, rgb: '0};

endpackage

`default_nettype wire
